//--- common/aes_tables_pkg.sv
package aes_tables_pkg;

    ////////////////////////////////////////////////////////////
    // Forward S-box
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // T0 entry, bytes {2S, S, S, 3S} from the top down
    function automatic logic [31:0] tbox_word(input logic [7:0] b);
        logic [7:0] s;
        logic [7:0] s2;
        s  = SBOX[b];
        s2 = xtime(s);
        return {s2, s, s, s2 ^ s};
    endfunction

    // One 128-bit state, byte 0 and column 0 in the top bits
    typedef union packed {
        logic [0:3][31:0]  col;
        logic [0:15][7:0]  bytes;
    } aes_state_u;

endpackage

//--- common/chain_pkg.sv
package chain_pkg;

    // Width of the state and of the key
    localparam int STATE_W = 128;

    // Round stages in the chain
    localparam int NUM_ROUNDS = 40;

    // Whitening block, XORed with the key to form the first state
    localparam logic [STATE_W-1:0] ROUND_SEED =
        128'hc2f45dfa_8acd3f4d_a3dcfe8a_93cefa0a;

    ////////////////////////////////////////////////////////////
    // Latency
    ////////////////////////////////////////////////////////////

    // Lookup register plus key mix register
    localparam int STAGES_PER_ROUND = 2;

    // Entry register, all rounds, exit register
    localparam int CHAIN_LATENCY = 1 + STAGES_PER_ROUND * NUM_ROUNDS + 1;

endpackage

//--- round/tbox_lookup.sv
`timescale 1ns/1ps

module tbox_lookup (
    input  logic        clk,
    input  logic        advance,
    input  logic [31:0] column,
    output logic [31:0] p0,
    output logic [31:0] p1,
    output logic [31:0] p2,
    output logic [31:0] p3
);
    import aes_tables_pkg::*;

    // One T0 word per row byte, row 0 first
    logic [0:3][31:0] t_q;

    ////////////////////////////////////////////////////////////
    // Table stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < 4; i++) begin
                t_q[i] <= tbox_word(column[31 - 8 * i -: 8]);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Row alignment
    ////////////////////////////////////////////////////////////

    // Row 0 already has the {2, 1, 1, 3} coefficient order
    assign p0 = t_q[0];

    // Row 1 wants {3, 2, 1, 1}, T0 rotated right by a byte
    assign p1 = {t_q[1][7:0], t_q[1][31:8]};

    // Row 2 wants {1, 3, 2, 1}
    assign p2 = {t_q[2][15:0], t_q[2][31:16]};

    // Row 3 wants {1, 1, 3, 2}
    assign p3 = {t_q[3][23:0], t_q[3][31:24]};

endmodule

//--- round/mix_round.sv
`timescale 1ns/1ps

module mix_round (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          advance,
    input  logic                          in_valid,
    input  aes_tables_pkg::aes_state_u    in_state,
    input  logic [chain_pkg::STATE_W-1:0] in_key,
    output logic                          out_valid,
    output aes_tables_pkg::aes_state_u    out_state,
    output logic [chain_pkg::STATE_W-1:0] out_key
);
    import aes_tables_pkg::*;

    // Lookup words indexed by source column
    logic [0:3][31:0] p0;
    logic [0:3][31:0] p1;
    logic [0:3][31:0] p2;
    logic [0:3][31:0] p3;

    // Valid and key riding along with the lookup stage
    logic       mid_valid;
    aes_state_u mid_key;

    aes_state_u mix_sum;

    ////////////////////////////////////////////////////////////
    // Stage 1 column lookups
    ////////////////////////////////////////////////////////////

    for (genvar c = 0; c < 4; c++) begin : g_col
        tbox_lookup u_lookup (
            .clk     (clk),
            .advance (advance),
            .column  (in_state.bytes[4 * c +: 4]),
            .p0      (p0[c]),
            .p1      (p1[c]),
            .p2      (p2[c]),
            .p3      (p3[c])
        );
    end

    // ShiftRows takes row r of output column j from column j + r
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            mix_sum.col[j] = p0[j] ^ p1[(j + 1) % 4] ^ p2[(j + 2) % 4] ^ p3[(j + 3) % 4]
                             ^ mid_key.col[j];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mid_valid <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            mid_valid <= in_valid;
            out_valid <= mid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mid_key   <= in_key;
            out_state <= mix_sum;
            out_key   <= mid_key;
        end
    end

    // Whole stage frozen during a stall
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        !advance |=> $stable(out_state) && $stable(out_key) && $stable(out_valid)
    ) else $error("mix_round output moved while advance was low");

endmodule

//--- logic/chain_entry.sv
`timescale 1ns/1ps

module chain_entry (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [chain_pkg::STATE_W-1:0] key,
    input  logic                          advance,
    output logic                          out_valid,
    output aes_tables_pkg::aes_state_u    out_state,
    output logic [chain_pkg::STATE_W-1:0] out_key
);
    import chain_pkg::*;

    logic               accept;
    logic               main_valid;
    logic [STATE_W-1:0] main_key;
    logic               skid_valid;
    logic [STATE_W-1:0] skid_key;

    assign accept = in_valid & in_ready;

    ////////////////////////////////////////////////////////////
    // Main register and skid slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (advance) begin
            if (skid_valid) begin
                // Parked key goes first, input is closed meanwhile
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
                in_ready   <= 1'b1;
            end else begin
                main_valid <= accept;
            end
        end else if (accept) begin
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (skid_valid) begin
                main_key <= skid_key;
            end else if (accept) begin
                main_key <= key;
            end
        end else if (accept) begin
            skid_key <= key;
        end
    end

    // Whitening of the first state
    assign out_valid = main_valid;
    assign out_state = main_key ^ ROUND_SEED;
    assign out_key   = main_key;

    a_no_accept_when_full: assert property (
        @(posedge clk) disable iff (rst)
        skid_valid |-> !(in_valid && in_ready)
    ) else $error("Key accepted with the skid slot occupied");

endmodule

//--- logic/chain_exit.sv
`timescale 1ns/1ps

module chain_exit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  aes_tables_pkg::aes_state_u    in_state,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [chain_pkg::STATE_W-1:0] out_data,
    output logic                          advance
);

    ////////////////////////////////////////////////////////////
    // Global advance
    ////////////////////////////////////////////////////////////

    // Chain moves when the output slot is free or being drained
    assign advance = ~out_valid | out_ready;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // Only real items overwrite the held result
    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            out_data <= in_state;
        end
    end

    // Stalled result must not move or vanish
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("out_data changed while stalled");

endmodule

//--- logic/round_chain_top.sv
`timescale 1ns/1ps

module round_chain_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [chain_pkg::STATE_W-1:0] key,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [chain_pkg::STATE_W-1:0] out_data
);
    import aes_tables_pkg::*;
    import chain_pkg::*;

    logic advance;

    // Index i feeds round i, the last index feeds the exit
    logic               stage_valid [0:NUM_ROUNDS];
    aes_state_u         stage_state [0:NUM_ROUNDS];
    logic [STATE_W-1:0] stage_key   [0:NUM_ROUNDS-1];

    chain_entry u_entry (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .key       (key),
        .advance   (advance),
        .out_valid (stage_valid[0]),
        .out_state (stage_state[0]),
        .out_key   (stage_key[0])
    );

    ////////////////////////////////////////////////////////////
    // Round stages
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROUNDS; i++) begin : g_round
        if (i < NUM_ROUNDS - 1) begin : g_mid
            mix_round u_round (
                .clk       (clk),
                .rst       (rst),
                .advance   (advance),
                .in_valid  (stage_valid[i]),
                .in_state  (stage_state[i]),
                .in_key    (stage_key[i]),
                .out_valid (stage_valid[i + 1]),
                .out_state (stage_state[i + 1]),
                .out_key   (stage_key[i + 1])
            );
        end else begin : g_last
            // Key stops here, only the state leaves the chain
            mix_round u_round (
                .clk       (clk),
                .rst       (rst),
                .advance   (advance),
                .in_valid  (stage_valid[i]),
                .in_state  (stage_state[i]),
                .in_key    (stage_key[i]),
                .out_valid (stage_valid[i + 1]),
                .out_state (stage_state[i + 1]),
                .out_key   ()
            );
        end
    end

    chain_exit u_exit (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (stage_valid[NUM_ROUNDS]),
        .in_state  (stage_state[NUM_ROUNDS]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .advance   (advance)
    );

endmodule

//--- testbench/chain_ref.svh
`ifndef CHAIN_REF_SVH
`define CHAIN_REF_SVH

localparam logic [31:0] LCG_SEED = 32'hc521;

// S-box rebuilt from field arithmetic at time zero
logic [7:0] sbox_table [0:255];

////////////////////////////////////////////////////////////
// GF(2^8) arithmetic
////////////////////////////////////////////////////////////

// Shift-and-add product, reduced by x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) p ^= x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// Brute-force search, zero maps to zero
function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
        if (gf_mul(a, 8'(y)) == 8'h01) inv = 8'(y);
    end
    return inv;
endfunction

function automatic logic [7:0] sbox_affine(input logic [7:0] b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
             ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

task automatic build_sbox_table();
    for (int v = 0; v < 256; v++) begin
        sbox_table[v] = sbox_affine(gf_inv(8'(v)));
    end
endtask

////////////////////////////////////////////////////////////
// Round model, byte i at bits 127-8i, row r of column c is byte 4c+r
////////////////////////////////////////////////////////////

function automatic logic [127:0] ref_round(input logic [127:0] st, input logic [127:0] rk);
    logic [7:0]   a [0:15];
    logic [7:0]   s [0:15];
    logic [127:0] res;
    for (int i = 0; i < 16; i++) begin
        a[i] = sbox_table[st[127 - 8 * i -: 8]];
    end
    // ShiftRows moves row r left by r columns
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            s[4 * c + r] = a[4 * ((c + r) % 4) + r];
        end
    end
    for (int c = 0; c < 4; c++) begin
        res[127 - 32 * c -: 8] = gf_mul(s[4 * c], 8'h02) ^ gf_mul(s[4 * c + 1], 8'h03)
                                 ^ s[4 * c + 2] ^ s[4 * c + 3];
        res[119 - 32 * c -: 8] = s[4 * c] ^ gf_mul(s[4 * c + 1], 8'h02)
                                 ^ gf_mul(s[4 * c + 2], 8'h03) ^ s[4 * c + 3];
        res[111 - 32 * c -: 8] = s[4 * c] ^ s[4 * c + 1]
                                 ^ gf_mul(s[4 * c + 2], 8'h02) ^ gf_mul(s[4 * c + 3], 8'h03);
        res[103 - 32 * c -: 8] = gf_mul(s[4 * c], 8'h03) ^ s[4 * c + 1] ^ s[4 * c + 2]
                                 ^ gf_mul(s[4 * c + 3], 8'h02);
    end
    return res ^ rk;
endfunction

function automatic logic [127:0] ref_chain(input logic [127:0] k);
    logic [127:0] st;
    st = k ^ ROUND_SEED;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
        st = ref_round(st, k);
    end
    return st;
endfunction

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- testbench/tb_round_chain.sv
`timescale 1ns/1ps

module tb_round_chain;
    import chain_pkg::*;

    `include "chain_ref.svh"

    localparam int RANDOM_ITEMS = 160;
    localparam int ITEM_COUNT   = 2 + 64 + RANDOM_ITEMS;
    localparam int CYCLE_LIMIT  = 4 * (ITEM_COUNT + CHAIN_LATENCY);

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [STATE_W-1:0] key;
    logic               out_valid;
    logic               out_ready;
    logic [STATE_W-1:0] out_data;

    // Expected results in acceptance order
    logic [STATE_W-1:0] exp_q [$];
    int                 accept_cycle_q [$];
    int                 accept_stall_q [$];

    int          cycle;
    int          stall_count;
    int          sent;
    int          accepted;
    int          compared;
    int          latency_checks;
    int          held_keys;
    int          value_errors;
    int          other_errors;
    bit          saw_ready_low;
    bit          inputs_done;
    logic [31:0] key_rng;
    logic [31:0] ready_rng;
    logic [STATE_W-1:0] k;

    round_chain_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .key       (key),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Protocol assertions
    ////////////////////////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clk) rst |-> !out_valid)
        else begin
            value_errors++;
            $display("ERROR: out_valid = %h during reset", out_valid);
        end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready && !out_valid)
        else begin
            value_errors++;
            $display("ERROR: in_ready = %h, out_valid = %h after reset", in_ready, out_valid);
        end

    a_stalled_output: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else begin
        value_errors++;
        $display("ERROR: out_data = %h moved or dropped while stalled", out_data);
    end

    ////////////////////////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [STATE_W-1:0] expected;
        int                 latency;
        int                 stalls;
        cycle++;
        if (!rst) begin
            if (!in_ready) saw_ready_low = 1'b1;
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_chain(key));
                accept_cycle_q.push_back(cycle);
                accept_stall_q.push_back(stall_count);
                accepted++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Output transfer with no accepted key waiting for it");
                end else begin
                    expected = exp_q.pop_front();
                    latency  = cycle - accept_cycle_q.pop_front();
                    stalls   = stall_count - accept_stall_q.pop_front();
                    compared++;
                    assert (out_data === expected) else begin
                        value_errors++;
                        $display("ERROR: out_data = %h, expected %h", out_data, expected);
                    end
                    // Only a stall-free trip has a fixed length
                    if (stalls == 0) begin
                        latency_checks++;
                        assert (latency == CHAIN_LATENCY) else begin
                            value_errors++;
                            $display("ERROR: latency = %h, expected %h", latency, CHAIN_LATENCY);
                        end
                    end
                end
            end
            if (out_valid && !out_ready) stall_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    // Holds valid and key until the handshake
    task automatic send_key(input logic [STATE_W-1:0] value);
        bit waited;
        waited   = 1'b0;
        in_valid = 1'b1;
        key      = value;
        sent++;
        do begin
            @(posedge clk);
            if (!in_ready) waited = 1'b1;
        end while (!in_ready);
        #0.5;
        in_valid = 1'b0;
        if (waited) held_keys++;
    endtask

    task automatic make_key(output logic [STATE_W-1:0] value);
        for (int w = 0; w < 4; w++) begin
            key_rng = lcg_step(key_rng);
            value[32 * w +: 32] = key_rng;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) idle_cycles(1);
    endtask

    task automatic drive_random_inputs();
        logic [STATE_W-1:0] value;
        for (int i = 0; i < RANDOM_ITEMS; i++) begin
            key_rng = lcg_step(key_rng);
            if (key_rng[31:30] == 2'b00) idle_cycles(1 + key_rng[29]);
            make_key(value);
            send_key(value);
        end
        inputs_done = 1'b1;
    endtask

    // Long stall first so the chain fills, then random back-pressure
    task automatic drive_random_ready();
        out_ready = 1'b0;
        idle_cycles(CHAIN_LATENCY + 16);
        assert (saw_ready_low) else begin
            other_errors++;
            $display("in_ready never dropped during the long output stall");
        end
        while (!inputs_done || exp_q.size() != 0) begin
            ready_rng = lcg_step(ready_rng);
            out_ready = ready_rng[31];
            idle_cycles(1);
        end
        out_ready = 1'b1;
    endtask

    task automatic close_run();
        $display("sent %0d, accepted %0d, compared %0d, timed %0d, errors %0d value, %0d other",
                 sent, accepted, compared, latency_checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        other_errors++;
        $display("Timeout after %0d cycles with %0d results still pending", cycle, exp_q.size());
        close_run();
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        key       = '0;
        out_ready = 1'b0;
        key_rng   = LCG_SEED;
        // Separate stream for back-pressure
        ready_rng = ~LCG_SEED;
        build_sbox_table();
        repeat (3) @(posedge clk);
        #0.5;
        rst       = 1'b0;
        out_ready = 1'b1;

        // All-zero key, then one random key on its own
        send_key('0);
        wait_drain();
        make_key(k);
        send_key(k);
        wait_drain();

        // Back-to-back stream
        repeat (64) begin
            make_key(k);
            send_key(k);
        end
        wait_drain();

        fork
            drive_random_inputs();
            drive_random_ready();
        join

        assert (held_keys > 0) else begin
            other_errors++;
            $display("No key ever had to wait for in_ready");
        end

        // Quiet window where a duplicated result would still come out
        idle_cycles(CHAIN_LATENCY + 4);
        close_run();
    end

endmodule

//--- compile.f
+incdir+testbench
common/aes_tables_pkg.sv
common/chain_pkg.sv
round/tbox_lookup.sv
round/mix_round.sv
logic/chain_entry.sv
logic/chain_exit.sv
logic/round_chain_top.sv
testbench/tb_round_chain.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_round_chain
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR, TOP, FLAGS, OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf $(OBJ_DIR)
